//--- verilog/aluPkg.sv
/*
  miniAluCore shared definitions
  widths, register file geometry and the operation encoding
*/
`default_nettype none

package aluPkg;

  // data path
  localparam int unsigned DataWidth = 32;

  // register file geometry
  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned NumRegs = 16;

  // instruction immediate, sign-extended in decode
  localparam int unsigned ImmWidth = 12;

  // retired-instruction counter, wraps
  localparam int unsigned CountWidth = 16;

  // operation field width
  localparam int unsigned OpWidth = 3;

  // supported operations
  // shifts use the low bits of operand B only
  typedef enum logic [OpWidth-1:0] {
    OpAdd  = 3'd0,
    OpSub  = 3'd1,
    OpAnd  = 3'd2,
    OpOr   = 3'd3,
    OpXor  = 3'd4,
    OpSll  = 3'd5,
    OpSrl  = 3'd6,
    OpAddi = 3'd7
  } aluOpE;

endpackage

`default_nettype wire

//--- verilog/aluOpIf.sv
/*
  aluOpIf
  decoded operation handed from decode to execute
*/
`timescale 1ns/1ps
`default_nettype none

interface aluOpIf
  import aluPkg::*;
();

  // one-cycle level per registered instruction
  logic                    opValid;
  aluOpE                   op;
  logic [RegAddrWidth-1:0] rd;
  logic [RegAddrWidth-1:0] rs1;
  logic [RegAddrWidth-1:0] rs2;
  // immediate already sign-extended to the data width
  logic [DataWidth-1:0]    immExt;

  modport decode (
    output opValid, op, rd, rs1, rs2, immExt
  );

  modport execute (
    input opValid, op, rd, rs1, rs2, immExt
  );

endinterface

`default_nettype wire

//--- verilog/instrDecode.sv
/*
  instrDecode
  samples a strobed instruction, sign-extends its immediate and
  registers the decoded operation for the execute stage
*/
`timescale 1ns/1ps
`default_nettype none

module instrDecode
  import aluPkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // instruction input
  input  wire logic                    instValid_i,
  input  wire aluOpE                   instOp_i,
  input  wire logic [RegAddrWidth-1:0] instRd_i,
  input  wire logic [RegAddrWidth-1:0] instRs1_i,
  input  wire logic [RegAddrWidth-1:0] instRs2_i,
  input  wire logic [ImmWidth-1:0]     instImm_i,
  // decoded operation towards execute
  aluOpIf.decode                       opIf
);

  logic [DataWidth-1:0] immSext;

  // replicate the immediate sign bit into the upper bits
  assign immSext = {{(DataWidth-ImmWidth){instImm_i[ImmWidth-1]}}, instImm_i};

  // valid follows the strobe each cycle
  // a cycle without an instruction drops it, so no stray write happens
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opIf.opValid <= 1'b0;
    end else begin
      opIf.opValid <= instValid_i;
    end
  end

  // operation fields, only loaded for a real instruction
  always_ff @(posedge clk_i) begin
    if (instValid_i) begin
      opIf.op     <= instOp_i;
      opIf.rd     <= instRd_i;
      opIf.rs1    <= instRs1_i;
      opIf.rs2    <= instRs2_i;
      opIf.immExt <= immSext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
/*
  regFile
  2**AddrWidth words, two combinational read ports and one write port,
  word 0 optionally tied to zero
*/
`timescale 1ns/1ps
`default_nettype none

module regFile #(
  parameter int unsigned DataWidth   = 32,
  parameter int unsigned AddrWidth   = 4,
  parameter bit          ZeroRegZero = 1'b1
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // read ports
  input  wire logic [AddrWidth-1:0] raddrA_i,
  input  wire logic [AddrWidth-1:0] raddrB_i,
  output logic      [DataWidth-1:0] rdataA_o,
  output logic      [DataWidth-1:0] rdataB_o,
  // write port
  input  wire logic                 we_i,
  input  wire logic [AddrWidth-1:0] waddr_i,
  input  wire logic [DataWidth-1:0] wdata_i
);

  localparam int unsigned NumWords = 2 ** AddrWidth;

  logic [DataWidth-1:0] mem [NumWords];
  logic [NumWords-1:0]  wordWe;

  // one-hot write enable per word
  always_comb begin
    for (int unsigned i = 0; i < NumWords; i++) begin
      wordWe[i] = we_i && (waddr_i == AddrWidth'(i));
    end
  end

  for (genvar w = 0; w < NumWords; w++) begin : gWord
    // word 0 ignores writes when tied to zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mem[w] <= '0;
      end else if (wordWe[w] && !(ZeroRegZero && (w == 0))) begin
        mem[w] <= wdata_i;
      end
    end
  end

  // asynchronous reads
  assign rdataA_o = mem[raddrA_i];
  assign rdataB_o = mem[raddrB_i];

endmodule

`default_nettype wire

//--- verilog/aluExecute.sv
/*
  aluExecute
  reads the source operands, computes the operation and writes the
  result back to the register file at the end of the cycle
*/
`timescale 1ns/1ps
`default_nettype none

module aluExecute
  import aluPkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // decoded operation from decode
  aluOpIf.execute                 opIf,
  // result towards the result stage
  output logic                    exValid_o,
  output logic [RegAddrWidth-1:0] exRd_o,
  output logic [DataWidth-1:0]    exData_o
);

  logic [DataWidth-1:0]         rs1Data;
  logic [DataWidth-1:0]         rs2Data;
  logic [DataWidth-1:0]         opA;
  logic [DataWidth-1:0]         opB;
  logic [$clog2(DataWidth)-1:0] shamt;
  logic [DataWidth-1:0]         result;

  // register 0 is hardwired to zero
  regFile #(
    .DataWidth  (DataWidth),
    .AddrWidth  (RegAddrWidth),
    .ZeroRegZero(1'b1)
  ) regFileInst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddrA_i(opIf.rs1),
    .raddrB_i(opIf.rs2),
    .rdataA_o(rs1Data),
    .rdataB_o(rs2Data),
    .we_i    (opIf.opValid),
    .waddr_i (opIf.rd),
    .wdata_i (result)
  );

  // operand select
  assign opA   = rs1Data;
  assign opB   = (opIf.op == OpAddi) ? opIf.immExt : rs2Data;
  // only the low bits give the shift distance
  assign shamt = opB[$clog2(DataWidth)-1:0];

  always_comb begin
    unique case (opIf.op)
      OpAdd:   result = opA + opB;
      OpSub:   result = opA - opB;
      OpAnd:   result = opA & opB;
      OpOr:    result = opA | opB;
      OpXor:   result = opA ^ opB;
      OpSll:   result = opA << shamt;
      OpSrl:   result = opA >> shamt;
      OpAddi:  result = opA + opB;
      default: result = '0;
    endcase
  end

  // the result is reported even for rd 0, the write there is dropped
  assign exValid_o = opIf.opValid;
  assign exRd_o    = opIf.rd;
  assign exData_o  = result;

endmodule

`default_nettype wire

//--- verilog/resultStage.sv
/*
  resultStage
  registers each result with a one-cycle valid pulse and
  counts retired instructions
*/
`timescale 1ns/1ps
`default_nettype none

module resultStage
  import aluPkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // result from execute
  input  wire logic                    exValid_i,
  input  wire logic [RegAddrWidth-1:0] exRd_i,
  input  wire logic [DataWidth-1:0]    exData_i,
  // registered output
  output logic                         resultValid_o,
  output logic      [RegAddrWidth-1:0] resultRd_o,
  output logic      [DataWidth-1:0]    resultData_o,
  output logic      [CountWidth-1:0]   retiredCount_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resultValid_o  <= 1'b0;
      resultRd_o     <= '0;
      resultData_o   <= '0;
      retiredCount_o <= '0;
    end else begin
      resultValid_o <= exValid_i;
      // rd and data hold until the next result
      if (exValid_i) begin
        resultRd_o     <= exRd_i;
        resultData_o   <= exData_i;
        retiredCount_o <= retiredCount_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/miniAluCore.sv
/*
  miniAluCore
  two-stage integer slice: decode register, then execute with
  register file writeback and a registered result
*/
`timescale 1ns/1ps
`default_nettype none

module miniAluCore
  import aluPkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // instruction strobe
  input  wire logic                    instValid_i,
  input  wire aluOpE                   instOp_i,
  input  wire logic [RegAddrWidth-1:0] instRd_i,
  input  wire logic [RegAddrWidth-1:0] instRs1_i,
  input  wire logic [RegAddrWidth-1:0] instRs2_i,
  input  wire logic [ImmWidth-1:0]     instImm_i,
  // result pulse
  output logic                         resultValid_o,
  output logic      [RegAddrWidth-1:0] resultRd_o,
  output logic      [DataWidth-1:0]    resultData_o,
  output logic      [CountWidth-1:0]   retiredCount_o
);

  aluOpIf opIf ();

  logic                    exValid;
  logic [RegAddrWidth-1:0] exRd;
  logic [DataWidth-1:0]    exData;

  instrDecode decodeInst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .instValid_i(instValid_i),
    .instOp_i   (instOp_i),
    .instRd_i   (instRd_i),
    .instRs1_i  (instRs1_i),
    .instRs2_i  (instRs2_i),
    .instImm_i  (instImm_i),
    .opIf       (opIf.decode)
  );

  aluExecute executeInst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .opIf     (opIf.execute),
    .exValid_o(exValid),
    .exRd_o   (exRd),
    .exData_o (exData)
  );

  resultStage resultInst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .exValid_i     (exValid),
    .exRd_i        (exRd),
    .exData_i      (exData),
    .resultValid_o (resultValid_o),
    .resultRd_o    (resultRd_o),
    .resultData_o  (resultData_o),
    .retiredCount_o(retiredCount_o)
  );

endmodule

`default_nettype wire

//--- tb/tbTasks.svh
/*
  testbench tasks for miniAluCore
  instruction driver, reference ALU, value check and directed tests
*/

function automatic logic [DataWidth-1:0] signExtend(input logic [ImmWidth-1:0] imm);
  logic signed [DataWidth-1:0] ext;
  ext = $signed(imm);
  return ext;
endfunction

// shifts take the low 5 bits of operand B and arithmetic wraps
function automatic logic [DataWidth-1:0] refAlu(input aluOpE op,
                                                input logic [DataWidth-1:0] a,
                                                input logic [DataWidth-1:0] b);
  case (op)
    OpAdd, OpAddi: return a + b;
    OpSub:         return a - b;
    OpAnd:         return a & b;
    OpOr:          return a | b;
    OpXor:         return a ^ b;
    OpSll:         return a << b[4:0];
    default:       return a >> b[4:0];
  endcase
endfunction

task automatic checkValue(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
  if (expected !== actual) begin
    $display("[FAIL] %s: %s expected 0x%h actual 0x%h", testName, what, expected, actual);
    errorCount++;
  end
endtask

// updates the model before driving on the edge
// result due 3 counts after the drive edge
task automatic issueInst(input aluOpE op, input logic [RegAddrWidth-1:0] rd,
                         input logic [RegAddrWidth-1:0] rs1,
                         input logic [RegAddrWidth-1:0] rs2,
                         input logic [ImmWidth-1:0] imm);
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] res;
  opB = (op == OpAddi) ? signExtend(imm) : regModel[rs2];
  res = refAlu(op, regModel[rs1], opB);
  if (rd != 0) begin
    regModel[rd] = res;
  end
  @(posedge clk);
  instValid <= 1'b1;
  instOp <= op;
  instRd <= rd;
  instRs1 <= rs1;
  instRs2 <= rs2;
  instImm <= imm;
  expRdQ.push_back(rd);
  expDataQ.push_back(res);
  dueQ.push_back(cycleCount + 3);
  issuedCount++;
endtask

task automatic idleCycles(input int n);
  repeat (n) begin
    @(posedge clk);
    instValid <= 1'b0;
  end
endtask

// stop issuing and wait until every result in flight was checked
task automatic expectResult();
  @(posedge clk);
  instValid <= 1'b0;
  while (dueQ.size() > 0) begin
    @(negedge clk);
  end
endtask

task automatic testReset();
  testName = "reset";
  @(negedge clk);
  checkValue("result valid", 0, resultValid);
  checkValue("retired count", 0, retiredCount);
  issueInst(OpAdd, 4'd1, 4'd2, 4'd3, 12'h0);
  expectResult();
endtask

task automatic testArith();
  testName = "arithmetic";
  issueInst(OpAddi, 4'd1, 4'd0, 4'd0, 12'h7ff);
  issueInst(OpAddi, 4'd2, 4'd0, 4'd0, 12'h800);
  issueInst(OpAdd, 4'd3, 4'd1, 4'd2, 12'h0);
  issueInst(OpSub, 4'd4, 4'd2, 4'd1, 12'h0);
  issueInst(OpAddi, 4'd5, 4'd0, 4'd0, 12'h001);
  issueInst(OpAddi, 4'd6, 4'd0, 4'd0, 12'd31);
  // top bit only, then doubled to wrap to zero
  issueInst(OpSll, 4'd7, 4'd5, 4'd6, 12'h0);
  issueInst(OpAdd, 4'd8, 4'd7, 4'd7, 12'h0);
  issueInst(OpSub, 4'd9, 4'd0, 4'd5, 12'h0);
  issueInst(OpAdd, 4'd9, 4'd9, 4'd5, 12'h0);
  issueInst(OpAddi, 4'd3, 4'd3, 4'd0, 12'h001);
  expectResult();
endtask

task automatic testLogicShift();
  testName = "logic and shifts";
  issueInst(OpAddi, 4'd10, 4'd0, 4'd0, 12'h5a5);
  issueInst(OpAddi, 4'd11, 4'd0, 4'd0, 12'hf0f);
  issueInst(OpAnd, 4'd12, 4'd10, 4'd11, 12'h0);
  issueInst(OpOr, 4'd13, 4'd10, 4'd11, 12'h0);
  issueInst(OpXor, 4'd14, 4'd10, 4'd11, 12'h0);
  // 36 shifts by 4
  issueInst(OpAddi, 4'd15, 4'd0, 4'd0, 12'd36);
  issueInst(OpSll, 4'd12, 4'd11, 4'd15, 12'h0);
  issueInst(OpSrl, 4'd13, 4'd11, 4'd15, 12'h0);
  issueInst(OpAddi, 4'd15, 4'd0, 4'd0, 12'h7ff);
  issueInst(OpSll, 4'd14, 4'd10, 4'd15, 12'h0);
  issueInst(OpSrl, 4'd14, 4'd11, 4'd15, 12'h0);
  expectResult();
endtask

task automatic testRegZero();
  testName = "register zero";
  issueInst(OpAddi, 4'd0, 4'd1, 4'd0, 12'h123);
  issueInst(OpAdd, 4'd5, 4'd0, 4'd0, 12'h0);
  issueInst(OpAdd, 4'd6, 4'd0, 4'd1, 12'h0);
  expectResult();
endtask

task automatic testBackToBack();
  logic [31:0]             r;
  aluOpE                   op;
  logic [RegAddrWidth-1:0] rd;
  logic [RegAddrWidth-1:0] rs1;
  logic [RegAddrWidth-1:0] rs2;
  logic [RegAddrWidth-1:0] lastRd;
  int                      i;
  testName = "back-to-back";
  lastRd = 4'd1;
  for (i = 0; i < NumRandInst; i++) begin
    r = $random(seed);
    op = aluOpE'(r[2:0]);
    rd = r[7:4];
    // about half the sources chain on the previous rd
    rs1 = r[8] ? lastRd : r[12:9];
    rs2 = r[13] ? lastRd : r[17:14];
    issueInst(op, rd, rs1, rs2, r[29:18]);
    lastRd = rd;
  end
  expectResult();
endtask

task automatic testIdleCount();
  testName = "idle gaps";
  issueInst(OpAddi, 4'd1, 4'd1, 4'd0, 12'h001);
  idleCycles(3);
  issueInst(OpAdd, 4'd2, 4'd1, 4'd1, 12'h0);
  idleCycles(5);
  issueInst(OpXor, 4'd3, 4'd2, 4'd1, 12'h0);
  expectResult();
  repeat (4) begin
    @(negedge clk);
    checkValue("idle valid", 0, resultValid);
  end
  checkValue("retired count", issuedCount, retiredCount);
endtask

//--- tb/tbMiniAluCore.sv
/*
  tbMiniAluCore
  directed testbench for the two-stage integer slice, with a reference
  register model, a result monitor and a cycle limit
*/
`timescale 1ns/1ps
`default_nettype none

module tbMiniAluCore
  import aluPkg::*;
();

  localparam int NumRandInst = 40;
  // the whole sequence needs well under 200 cycles
  localparam int CycleLimit = 2000;

  logic                    clk;
  logic                    rstN;
  logic                    instValid;
  aluOpE                   instOp;
  logic [RegAddrWidth-1:0] instRd;
  logic [RegAddrWidth-1:0] instRs1;
  logic [RegAddrWidth-1:0] instRs2;
  logic [ImmWidth-1:0]     instImm;
  logic                    resultValid;
  logic [RegAddrWidth-1:0] resultRd;
  logic [DataWidth-1:0]    resultData;
  logic [CountWidth-1:0]   retiredCount;

  // reference register file, updated in program order
  logic [DataWidth-1:0] regModel [NumRegs];

  // results still in flight
  logic [RegAddrWidth-1:0] expRdQ [$];
  logic [DataWidth-1:0]    expDataQ [$];
  int                      dueQ [$];

  logic [RegAddrWidth-1:0] expRd;
  logic [DataWidth-1:0]    expData;
  int                      dueCycle;

  integer seed;
  int     cycleCount = 0;
  int     errorCount = 0;
  int     issuedCount = 0;
  string  testName = "none";

  miniAluCore UUT (
    .clk_i         (clk),
    .rst_ni        (rstN),
    .instValid_i   (instValid),
    .instOp_i      (instOp),
    .instRd_i      (instRd),
    .instRs1_i     (instRs1),
    .instRs2_i     (instRs2),
    .instImm_i     (instImm),
    .resultValid_o (resultValid),
    .resultRd_o    (resultRd),
    .resultData_o  (resultData),
    .retiredCount_o(retiredCount)
  );

  `include "tbTasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // cycle limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  // every result pulse is matched against the oldest instruction in flight
  always @(negedge clk) begin
    if (rstN) begin
      if (resultValid) begin
        if (dueQ.size() == 0) begin
          $display("ERROR: %s: result pulse with no instruction in flight", testName);
          errorCount++;
        end else begin
          expRd = expRdQ.pop_front();
          expData = expDataQ.pop_front();
          dueCycle = dueQ.pop_front();
          checkValue("latency", dueCycle, cycleCount);
          checkValue("result rd", expRd, resultRd);
          checkValue("result data", expData, resultData);
        end
      end else if (dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
        $display("ERROR: %s: no result pulse arrived for rd %0d", testName, expRdQ[0]);
        errorCount++;
        expRd = expRdQ.pop_front();
        expData = expDataQ.pop_front();
        dueCycle = dueQ.pop_front();
      end
    end
  end

  initial begin
    seed = 32'h49e3;
    rstN = 1'b0;
    instValid = 1'b0;
    instOp = OpAdd;
    instRd = '0;
    instRs1 = '0;
    instRs2 = '0;
    instImm = '0;
    for (int i = 0; i < NumRegs; i++) begin
      regModel[i] = '0;
    end
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    testReset();
    testArith();
    testLogicShift();
    testRegZero();
    testBackToBack();
    testIdleCount();

    repeat (2) @(negedge clk);
    $display("%0d errors over %0d instructions", errorCount, issuedCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
verilog/aluPkg.sv
verilog/aluOpIf.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/resultStage.sv
verilog/miniAluCore.sv
tb/tbMiniAluCore.sv
